//--- Makefile
# Verilator build and run of the memory issue path testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f all.f --top-module tb_mem_issue -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module tb_mem_issue
	verilator --lint-only +incdir+logic logic/mem_iq_pkg.sv logic/scoreboard_mem.sv \
	  logic/mem_issue_queue.sv logic/mem_iq_ctrl_regs.sv logic/mem_issue_top.sv \
	  --top-module mem_issue_top

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+logic
+incdir+verif
logic/mem_iq_pkg.sv
logic/scoreboard_mem.sv
logic/mem_issue_queue.sv
logic/mem_iq_ctrl_regs.sv
logic/mem_issue_top.sv
verif/tb_mem_issue.sv

//--- logic/mem_iq_cfg.svh
/*
 * Widths and sizes of the memory issue path
 * Dispatch lanes, writeback ports, PRF, issue queue and CSR address
 */

`ifndef MEM_IQ_CFG_SVH
`define MEM_IQ_CFG_SVH

// Front end and writeback
`define DISPATCH_WIDTH 2
`define PRF_INT_WAYS 2

// Integer physical register file
`define PRF_INT_SIZE 64
`define PRF_INT_INDEX_SIZE 6

// Memory issue queue
`define IQ_MEM_SIZE 8
`define IQ_SLOT_INDEX_SIZE 3
`define OP_ID_SIZE 8

`define CSR_ADDR_SIZE 2

`endif

//--- logic/mem_iq_ctrl_regs.sv
/*
 * Control and status registers of the memory issue queue
 * Issue enable, flush pulse, issued counter and the read mux
 */

`timescale 1ns/1ns

`include "mem_iq_cfg.svh"

module mem_iq_ctrl_regs (
  input  logic clock,
  input  logic rst_n,
  input  logic csr_write,
  input  logic [`CSR_ADDR_SIZE-1:0] csr_addr,
  input  logic [15:0] csr_wdata,
  output logic [15:0] csr_rdata,
  input  mem_iq_pkg::slot_count_t occupancy,
  input  logic issue_valid,
  output logic issue_enable,
  output logic flush
);

  localparam logic [`CSR_ADDR_SIZE-1:0] ADDR_CTRL = 2'd0;
  localparam logic [`CSR_ADDR_SIZE-1:0] ADDR_STATUS_OCC = 2'd1;
  localparam logic [`CSR_ADDR_SIZE-1:0] ADDR_STATUS_ISSUED = 2'd2;

  mem_iq_pkg::issue_count_t issue_count;
  logic ctrl_write;

  assign ctrl_write = csr_write && (csr_addr == ADDR_CTRL);

  // Bit 0 is a plain level, bit 1 only fires the flush pulse
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      issue_enable <= 1'b0;
      flush <= 1'b0;
    end else begin
      flush <= ctrl_write && csr_wdata[1];
      if (ctrl_write) begin
        issue_enable <= csr_wdata[0];
      end
    end
  end

  // Issued operations since the last flush, wraps
  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      issue_count <= '0;
    end else if (issue_valid) begin
      issue_count <= issue_count + 1'b1;
    end
  end

  always_comb begin
    case (csr_addr)
      ADDR_CTRL:          csr_rdata = {15'd0, issue_enable};
      ADDR_STATUS_OCC:    csr_rdata = 16'(occupancy);
      ADDR_STATUS_ISSUED: csr_rdata = issue_count;
      default:            csr_rdata = '0;
    endcase
  end

endmodule

//--- logic/mem_iq_pkg.sv
/*
 * Shared types of the memory issue path
 * Register index, op id, counters and the slot state enum
 */

`include "mem_iq_cfg.svh"

package mem_iq_pkg;

  typedef logic [`PRF_INT_INDEX_SIZE-1:0] prf_index_t;
  typedef logic [`OP_ID_SIZE-1:0] op_id_t;

  // Holds 0 up to IQ_MEM_SIZE, hence one bit above the slot index
  typedef logic [`IQ_SLOT_INDEX_SIZE:0] slot_count_t;

  typedef logic [15:0] issue_count_t;

  // ISSUED covers the cycle in which the issue output is registered
  typedef enum logic [1:0] {
    SLOT_FREE = 2'd0,
    SLOT_WAIT = 2'd1,
    SLOT_ISSUED = 2'd2
  } slot_state_t;

endpackage

//--- logic/mem_issue_queue.sv
/*
 * Memory issue queue
 * Slot storage, allocation, readiness, lowest-slot select, registered issue
 */

`timescale 1ns/1ns

`include "mem_iq_cfg.svh"

module mem_issue_queue (
  input  logic clock,
  input  logic rst_n,
  input  logic flush,
  input  logic issue_enable,
  // Dispatch lanes
  input  logic [`DISPATCH_WIDTH-1:0] dispatch_valid,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_dest,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs1,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs2,
  input  mem_iq_pkg::op_id_t [`DISPATCH_WIDTH-1:0] dispatch_op_id,
  output logic dispatch_ready,
  // Scoreboard
  output logic [`DISPATCH_WIDTH-1:0] set_busy_valid,
  output mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_busy_index,
  output mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs1_index,
  output mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs2_index,
  input  logic [`IQ_MEM_SIZE-1:0] rs1_busy,
  input  logic [`IQ_MEM_SIZE-1:0] rs2_busy,
  // Issue
  output logic issue_valid,
  output mem_iq_pkg::op_id_t issue_op_id,
  output mem_iq_pkg::prf_index_t issue_rs1,
  output mem_iq_pkg::prf_index_t issue_rs2,
  output mem_iq_pkg::slot_count_t occupancy
);

  mem_iq_pkg::slot_state_t slot_state [`IQ_MEM_SIZE];
  mem_iq_pkg::op_id_t [`IQ_MEM_SIZE-1:0] slot_op_id;
  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] slot_rs1;
  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] slot_rs2;

  mem_iq_pkg::slot_count_t free_count;
  logic [`DISPATCH_WIDTH-1:0] lane_accept;
  logic [`DISPATCH_WIDTH-1:0][`IQ_SLOT_INDEX_SIZE-1:0] alloc_slot;

  logic [`IQ_MEM_SIZE-1:0] slot_ready;
  logic sel_valid;
  logic [`IQ_SLOT_INDEX_SIZE-1:0] sel_slot;
  logic do_issue;

  // Occupancy and back-pressure
  always_comb begin
    free_count = '0;
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      if (slot_state[s] == mem_iq_pkg::SLOT_FREE) begin
        free_count = free_count + 1'b1;
      end
    end
  end

  assign occupancy = mem_iq_pkg::slot_count_t'(`IQ_MEM_SIZE) - free_count;
  assign dispatch_ready = (free_count >= `DISPATCH_WIDTH);
  assign lane_accept = dispatch_valid & {`DISPATCH_WIDTH{dispatch_ready}};

  // Lane 0 gets the lowest free slot, lane 1 the next one
  always_comb begin
    int unsigned taken;
    taken = 0;
    alloc_slot = '0;
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      if (slot_state[s] == mem_iq_pkg::SLOT_FREE && taken < `DISPATCH_WIDTH) begin
        alloc_slot[taken] = `IQ_SLOT_INDEX_SIZE'(s);
        taken = taken + 1;
      end
    end
  end

  // Destinations go busy at the dispatch edge
  assign set_busy_valid = lane_accept;
  assign set_busy_index = dispatch_dest;

  assign rs1_index = slot_rs1;
  assign rs2_index = slot_rs2;

  // Waiting slot with both sources free
  always_comb begin
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      slot_ready[s] = (slot_state[s] == mem_iq_pkg::SLOT_WAIT) && !rs1_busy[s] && !rs2_busy[s];
    end
  end

  // Lowest ready slot wins, scanned from the top down
  always_comb begin
    sel_valid = 1'b0;
    sel_slot = '0;
    for (int s = `IQ_MEM_SIZE - 1; s >= 0; s--) begin
      if (slot_ready[s]) begin
        sel_valid = 1'b1;
        sel_slot = `IQ_SLOT_INDEX_SIZE'(s);
      end
    end
  end

  assign do_issue = sel_valid && issue_enable && !flush;

  // Slot state, flush empties the whole queue
  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
        slot_state[s] <= mem_iq_pkg::SLOT_FREE;
      end
    end else begin
      for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
        if (slot_state[s] == mem_iq_pkg::SLOT_ISSUED) begin
          slot_state[s] <= mem_iq_pkg::SLOT_FREE;
        end
      end
      if (do_issue) begin
        slot_state[sel_slot] <= mem_iq_pkg::SLOT_ISSUED;
      end
      for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
        if (lane_accept[l]) begin
          slot_state[alloc_slot[l]] <= mem_iq_pkg::SLOT_WAIT;
        end
      end
    end
  end

  // Slot payload
  always_ff @(posedge clock) begin
    for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
      if (lane_accept[l]) begin
        slot_op_id[alloc_slot[l]] <= dispatch_op_id[l];
        slot_rs1[alloc_slot[l]] <= dispatch_rs1[l];
        slot_rs2[alloc_slot[l]] <= dispatch_rs2[l];
      end
    end
  end

  // Registered issue output
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= do_issue;
    end
  end

  always_ff @(posedge clock) begin
    if (do_issue) begin
      issue_op_id <= slot_op_id[sel_slot];
      issue_rs1 <= slot_rs1[sel_slot];
      issue_rs2 <= slot_rs2[sel_slot];
    end
  end

endmodule

//--- logic/mem_issue_top.sv
/*
 * Top of the memory issue path
 * Queue, banked scoreboard and control registers
 */

`timescale 1ns/1ns

`include "mem_iq_cfg.svh"

module mem_issue_top (
  input  logic clock,
  input  logic rst_n,
  // Dispatch
  input  logic [`DISPATCH_WIDTH-1:0] dispatch_valid,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_dest,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs1,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs2,
  input  mem_iq_pkg::op_id_t [`DISPATCH_WIDTH-1:0] dispatch_op_id,
  output logic dispatch_ready,
  // Writeback
  input  logic [`PRF_INT_WAYS-1:0] wb_valid,
  input  mem_iq_pkg::prf_index_t [`PRF_INT_WAYS-1:0] wb_index,
  // Control registers
  input  logic csr_write,
  input  logic [`CSR_ADDR_SIZE-1:0] csr_addr,
  input  logic [15:0] csr_wdata,
  output logic [15:0] csr_rdata,
  // Issue
  output logic issue_valid,
  output mem_iq_pkg::op_id_t issue_op_id,
  output mem_iq_pkg::prf_index_t issue_rs1,
  output mem_iq_pkg::prf_index_t issue_rs2
);

  logic flush;
  logic issue_enable;
  mem_iq_pkg::slot_count_t occupancy;

  logic [`DISPATCH_WIDTH-1:0] set_busy_valid;
  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_busy_index;
  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs1_index;
  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs2_index;
  logic [`IQ_MEM_SIZE-1:0] rs1_busy;
  logic [`IQ_MEM_SIZE-1:0] rs2_busy;

  mem_issue_queue u_queue (
    .clock          (clock),
    .rst_n          (rst_n),
    .flush          (flush),
    .issue_enable   (issue_enable),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_rs1   (dispatch_rs1),
    .dispatch_rs2   (dispatch_rs2),
    .dispatch_op_id (dispatch_op_id),
    .dispatch_ready (dispatch_ready),
    .set_busy_valid (set_busy_valid),
    .set_busy_index (set_busy_index),
    .rs1_index      (rs1_index),
    .rs2_index      (rs2_index),
    .rs1_busy       (rs1_busy),
    .rs2_busy       (rs2_busy),
    .issue_valid    (issue_valid),
    .issue_op_id    (issue_op_id),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .occupancy      (occupancy)
  );

  // Writebacks free registers, flush wipes every bank
  scoreboard_mem u_scoreboard (
    .clock            (clock),
    .rst_n            (rst_n),
    .clear            (flush),
    .set_busy_valid   (set_busy_valid),
    .set_busy_index   (set_busy_index),
    .clear_busy_valid (wb_valid),
    .clear_busy_index (wb_index),
    .rs1_index        (rs1_index),
    .rs2_index        (rs2_index),
    .rs1_busy         (rs1_busy),
    .rs2_busy         (rs2_busy)
  );

  mem_iq_ctrl_regs u_ctrl_regs (
    .clock        (clock),
    .rst_n        (rst_n),
    .csr_write    (csr_write),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .occupancy    (occupancy),
    .issue_valid  (issue_valid),
    .issue_enable (issue_enable),
    .flush        (flush)
  );

endmodule

//--- logic/scoreboard_mem.sv
/*
 * Banked PRF busy table for the memory issue queue
 * One busy vector per slot, writeback bypass on the lookups
 */

`timescale 1ns/1ns

`include "mem_iq_cfg.svh"

module scoreboard_mem (
  input  logic clock,
  input  logic rst_n,
  input  logic clear,
  // Destinations of accepted dispatch lanes
  input  logic [`DISPATCH_WIDTH-1:0] set_busy_valid,
  input  mem_iq_pkg::prf_index_t [`DISPATCH_WIDTH-1:0] set_busy_index,
  // Writeback ports
  input  logic [`PRF_INT_WAYS-1:0] clear_busy_valid,
  input  mem_iq_pkg::prf_index_t [`PRF_INT_WAYS-1:0] clear_busy_index,
  // Per-slot source lookups
  input  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs1_index,
  input  mem_iq_pkg::prf_index_t [`IQ_MEM_SIZE-1:0] rs2_index,
  output logic [`IQ_MEM_SIZE-1:0] rs1_busy,
  output logic [`IQ_MEM_SIZE-1:0] rs2_busy
);

  // Every bank holds the same content, kept next to its slot
  logic [`PRF_INT_SIZE-1:0] busy_bank [`IQ_MEM_SIZE];

  logic [`PRF_INT_SIZE-1:0] set_req;
  logic [`PRF_INT_SIZE-1:0] clear_req;

  logic [`IQ_MEM_SIZE-1:0][`PRF_INT_WAYS-1:0] rs1_wb_hit;
  logic [`IQ_MEM_SIZE-1:0][`PRF_INT_WAYS-1:0] rs2_wb_hit;

  // Decode dispatch lanes into a set mask
  always_comb begin
    set_req = '0;
    for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
      if (set_busy_valid[l]) begin
        set_req[set_busy_index[l]] = 1'b1;
      end
    end
  end

  // Decode writeback ways into a clear mask
  always_comb begin
    clear_req = '0;
    for (int w = 0; w < `PRF_INT_WAYS; w++) begin
      if (clear_busy_valid[w]) begin
        clear_req[clear_busy_index[w]] = 1'b1;
      end
    end
  end

  // Writeback match per slot and per way
  generate
    for (genvar s = 0; s < `IQ_MEM_SIZE; s++) begin : g_slot_hit
      for (genvar w = 0; w < `PRF_INT_WAYS; w++) begin : g_way_hit
        assign rs1_wb_hit[s][w] = clear_busy_valid[w] && (clear_busy_index[w] == rs1_index[s]);
        assign rs2_wb_hit[s][w] = clear_busy_valid[w] && (clear_busy_index[w] == rs2_index[s]);
      end
    end
  endgenerate

  // Lookup with bypass, a writeback this cycle reads as free
  always_comb begin
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      rs1_busy[s] = busy_bank[s][rs1_index[s]] && !(|rs1_wb_hit[s]);
      rs2_busy[s] = busy_bank[s][rs2_index[s]] && !(|rs2_wb_hit[s]);
    end
  end

  // Clear beats set on the same index
  always_ff @(posedge clock) begin
    if (!rst_n || clear) begin
      for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
        busy_bank[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
        busy_bank[s] <= (busy_bank[s] | set_req) & ~clear_req;
      end
    end
  end

endmodule

//--- verif/tb_mem_issue_vectors.svh
/*
 * Test table of the memory issue testbench
 * Dispatch groups, writebacks, CTRL writes and expected issue order
 */

`ifndef TB_MEM_ISSUE_VECTORS_SVH
`define TB_MEM_ISSUE_VECTORS_SVH

// Writeback delay below zero means driven together with group (-delay-1)
task automatic load_tests();
  begin_test("ready_slot_order", -1, 0, 1'b0);
  group_ctrl(0, 1);
  lane(0, 0, 5'h01, 6'd40, 6'd1, 6'd2);
  lane(0, 1, 5'h02, 6'd41, 6'd3, 6'd4);
  lane(1, 0, 5'h03, 6'd42, 6'd5, 6'd6);
  lane(1, 1, 5'h04, 6'd43, 6'd7, 6'd8);
  expect_issue(5'h01, 6'd1, 6'd2);
  expect_issue(5'h02, 6'd3, 6'd4);
  expect_issue(5'h03, 6'd5, 6'd6);
  expect_issue(5'h04, 6'd7, 6'd8);

  begin_test("wait_on_writeback", -1, 0, 1'b0);
  lane(0, 0, 5'h05, 6'd13, 6'd4, 6'd5);
  lane(1, 0, 5'h06, 6'd14, 6'd13, 6'd6);
  lane(1, 1, 5'h07, 6'd15, 6'd7, 6'd8);
  lane(2, 0, 5'h0c, 6'd12, 6'd9, 6'd10);
  // Slot 1 sees this writeback through the bypass and beats ready slot 3
  writeback(6'd13, 0);
  expect_issue(5'h05, 6'd4, 6'd5);
  expect_issue(5'h07, 6'd7, 6'd8);
  expect_issue(5'h06, 6'd13, 6'd6);
  expect_issue(5'h0c, 6'd9, 6'd10);

  begin_test("group_dependency", -1, 0, 1'b0);
  lane(0, 0, 5'h08, 6'd16, 6'd1, 6'd2);
  lane(0, 1, 5'h09, 6'd17, 6'd16, 6'd3);
  lane(1, 0, 5'h0a, 6'd18, 6'd4, 6'd5);
  lane(2, 0, 5'h0b, 6'd19, 6'd18, 6'd6);
  // Set and clear of 18 at the same edge
  writeback(6'd18, -2);
  writeback(6'd16, 3);
  expect_issue(5'h08, 6'd1, 6'd2);
  expect_issue(5'h0a, 6'd4, 6'd5);
  expect_issue(5'h0b, 6'd18, 6'd6);
  expect_issue(5'h09, 6'd16, 6'd3);

  begin_test("backpressure", 1, 8, 1'b0);
  group_ctrl(0, 0);
  for (int g = 0; g < 4; g++) begin
    lane(g, 0, 5'(8'h10 + 2 * g), 6'(20 + 2 * g), 6'd1, 6'd2);
    lane(g, 1, 5'(8'h11 + 2 * g), 6'(21 + 2 * g), 6'd3, 6'd4);
  end
  for (int i = 0; i < 8; i++) begin
    expect_issue(5'(8'h10 + i), (i % 2 == 0) ? 6'd1 : 6'd3, (i % 2 == 0) ? 6'd2 : 6'd4);
  end

  begin_test("flush", -1, 0, 1'b0);
  group_ctrl(0, 0);
  lane(0, 0, 5'h18, 6'd30, 6'd1, 6'd2);
  lane(0, 1, 5'h19, 6'd31, 6'd30, 6'd3);
  // Flush and enable before an op that reads both flushed destinations
  group_ctrl(1, 3);
  lane(1, 0, 5'h1a, 6'd32, 6'd30, 6'd31);
  expect_issue(5'h1a, 6'd30, 6'd31);
endtask

`endif

//--- verif/tb_mem_issue.sv
/*
 * Testbench of the memory issue path
 * Clock, reset, table driver, issue monitor and checks
 */

`timescale 1ns/1ns

`include "mem_iq_cfg.svh"

module tb_mem_issue;

  localparam int NT = 8;
  localparam int NG = 4;
  localparam int NE = 8;

  logic clock;
  logic rst_n;
  logic [1:0] dispatch_valid;
  mem_iq_pkg::prf_index_t [1:0] dispatch_dest;
  mem_iq_pkg::prf_index_t [1:0] dispatch_rs1;
  mem_iq_pkg::prf_index_t [1:0] dispatch_rs2;
  mem_iq_pkg::op_id_t [1:0] dispatch_op_id;
  logic dispatch_ready;
  logic [1:0] wb_valid;
  mem_iq_pkg::prf_index_t [1:0] wb_index;
  logic csr_write;
  logic [1:0] csr_addr;
  logic [15:0] csr_wdata;
  logic [15:0] csr_rdata;
  logic issue_valid;
  mem_iq_pkg::op_id_t issue_op_id;
  mem_iq_pkg::prf_index_t issue_rs1;
  mem_iq_pkg::prf_index_t issue_rs2;

  // Test table storage
  string t_name [NT];
  int t_groups [NT];
  int t_ctrl_end [NT];
  int t_mid_occ [NT];
  logic t_mid_ready [NT];
  int g_ctrl [NT][NG];
  logic g_valid [NT][NG][2];
  logic [4:0] g_op [NT][NG][2];
  logic [5:0] g_dest [NT][NG][2];
  logic [5:0] g_rs1 [NT][NG][2];
  logic [5:0] g_rs2 [NT][NG][2];
  int t_nwb [NT];
  logic [5:0] wb_idx [NT][2];
  int wb_delay [NT][2];
  int t_nexp [NT];
  logic [4:0] e_op [NT][NE];
  logic [5:0] e_rs1 [NT][NE];
  logic [5:0] e_rs2 [NT][NE];
  int n_tests = 0;

  // Random upper op id bits, indexed by the low bits
  logic [2:0] op_hi [32];

  logic [7:0] mon_op [$];
  logic [5:0] mon_rs1 [$];
  logic [5:0] mon_rs2 [$];
  int since_flush = 0;
  int errors = 0;
  int test_errors = 0;
  logic timed_out = 1'b0;

  mem_issue_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    if (rst_n && issue_valid) begin
      mon_op.push_back(issue_op_id);
      mon_rs1.push_back(issue_rs1);
      mon_rs2.push_back(issue_rs2);
      since_flush = since_flush + 1;
    end
  end

  task automatic begin_test(string name, int ctrl_end, int mid_occ, logic mid_ready);
    t_name[n_tests] = name;
    t_groups[n_tests] = 0;
    t_ctrl_end[n_tests] = ctrl_end;
    t_mid_occ[n_tests] = mid_occ;
    t_mid_ready[n_tests] = mid_ready;
    t_nwb[n_tests] = 0;
    t_nexp[n_tests] = 0;
    for (int g = 0; g < NG; g++) begin
      g_ctrl[n_tests][g] = -1;
      g_valid[n_tests][g][0] = 1'b0;
      g_valid[n_tests][g][1] = 1'b0;
    end
    n_tests = n_tests + 1;
  endtask

  task automatic group_ctrl(int g, int val);
    g_ctrl[n_tests-1][g] = val;
  endtask

  task automatic lane(int g, int l, logic [4:0] op, logic [5:0] dest, logic [5:0] rs1,
                      logic [5:0] rs2);
    int t;
    t = n_tests - 1;
    g_valid[t][g][l] = 1'b1;
    g_op[t][g][l] = op;
    g_dest[t][g][l] = dest;
    g_rs1[t][g][l] = rs1;
    g_rs2[t][g][l] = rs2;
    if (g + 1 > t_groups[t]) t_groups[t] = g + 1;
  endtask

  task automatic writeback(logic [5:0] idx, int delay);
    wb_idx[n_tests-1][t_nwb[n_tests-1]] = idx;
    wb_delay[n_tests-1][t_nwb[n_tests-1]] = delay;
    t_nwb[n_tests-1] = t_nwb[n_tests-1] + 1;
  endtask

  task automatic expect_issue(logic [4:0] op, logic [5:0] rs1, logic [5:0] rs2);
    e_op[n_tests-1][t_nexp[n_tests-1]] = op;
    e_rs1[n_tests-1][t_nexp[n_tests-1]] = rs1;
    e_rs2[n_tests-1][t_nexp[n_tests-1]] = rs2;
    t_nexp[n_tests-1] = t_nexp[n_tests-1] + 1;
  endtask

  `include "tb_mem_issue_vectors.svh"

  task automatic check(string sig, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR t=%0t %s expected=0x%0h actual=0x%0h", $time, sig, expected, actual);
      errors = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic report_timeout(string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  task automatic write_ctrl(int val);
    csr_addr = 2'd0;
    csr_wdata = 16'(val);
    csr_write = 1'b1;
    next_cycle();
    csr_write = 1'b0;
    // Flush pulse lands at the following edge
    next_cycle();
    if (val[1]) since_flush = 0;
  endtask

  task automatic read_csr(logic [1:0] addr, output logic [15:0] data);
    csr_addr = addr;
    #1;
    data = csr_rdata;
  endtask

  task automatic dispatch_group(int t, int g);
    int n;
    logic [31:0] rnd;
    if (g_ctrl[t][g] >= 0) write_ctrl(g_ctrl[t][g]);
    n = 0;
    while (!dispatch_ready && n < 100) begin
      next_cycle();
      n = n + 1;
    end
    if (!dispatch_ready) begin
      report_timeout("dispatch_ready");
      return;
    end
    for (int l = 0; l < 2; l++) begin
      rnd = $urandom;
      op_hi[g_op[t][g][l]] = rnd[2:0];
      dispatch_valid[l] = g_valid[t][g][l];
      dispatch_op_id[l] = {rnd[2:0], g_op[t][g][l]};
      dispatch_dest[l] = g_dest[t][g][l];
      dispatch_rs1[l] = g_rs1[t][g][l];
      dispatch_rs2[l] = g_rs2[t][g][l];
    end
    for (int k = 0; k < t_nwb[t]; k++) begin
      if (wb_delay[t][k] == -(g + 1)) begin
        wb_valid[k] = 1'b1;
        wb_index[k] = wb_idx[t][k];
      end
    end
    next_cycle();
    dispatch_valid = '0;
    wb_valid = '0;
  endtask

  task automatic run_test(int t);
    int n;
    int max_delay;
    logic [15:0] data;
    test_errors = 0;
    mon_op.delete();
    mon_rs1.delete();
    mon_rs2.delete();
    for (int g = 0; g < t_groups[t] && !timed_out; g++) dispatch_group(t, g);
    if (timed_out) return;
    max_delay = -1;
    for (int k = 0; k < t_nwb[t]; k++) begin
      if (wb_delay[t][k] > max_delay) max_delay = wb_delay[t][k];
    end
    for (int d = 0; d <= max_delay; d++) begin
      for (int k = 0; k < t_nwb[t]; k++) begin
        if (wb_delay[t][k] == d) begin
          wb_valid[k] = 1'b1;
          wb_index[k] = wb_idx[t][k];
        end
      end
      next_cycle();
      wb_valid = '0;
    end
    if (t_ctrl_end[t] >= 0) begin
      read_csr(2'd1, data);
      check("STATUS_OCC", t_mid_occ[t], data);
      check("dispatch_ready", t_mid_ready[t], dispatch_ready);
      check("issue_valid count", 0, mon_op.size());
      next_cycle();
      write_ctrl(t_ctrl_end[t]);
    end
    n = 0;
    while (mon_op.size() < t_nexp[t] && n < 200) begin
      next_cycle();
      n = n + 1;
    end
    if (mon_op.size() < t_nexp[t]) begin
      report_timeout("the expected issues");
      return;
    end
    // Quiet window to catch an extra issue
    repeat (6) next_cycle();
    check("issue_valid count", t_nexp[t], mon_op.size());
    for (int i = 0; i < t_nexp[t] && i < mon_op.size(); i++) begin
      check("issue_op_id", {op_hi[e_op[t][i]], e_op[t][i]}, mon_op[i]);
      check("issue_rs1", e_rs1[t][i], mon_rs1[i]);
      check("issue_rs2", e_rs2[t][i], mon_rs2[i]);
    end
    read_csr(2'd1, data);
    check("STATUS_OCC", 0, data);
    read_csr(2'd2, data);
    check("STATUS_ISSUED", since_flush, data);
    next_cycle();
    $display("test %s done with %0d mismatches", t_name[t], test_errors);
  endtask

  initial begin
    logic [31:0] seed_val;
    int done;
    seed_val = $urandom(32'h9a7b_3816);
    rst_n = 1'b0;
    dispatch_valid = '0;
    dispatch_dest = '0;
    dispatch_rs1 = '0;
    dispatch_rs2 = '0;
    dispatch_op_id = '0;
    wb_valid = '0;
    wb_index = '0;
    csr_write = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    load_tests();
    repeat (16) @(posedge clock);
    #1;
    rst_n = 1'b1;
    check("dispatch_ready", 1, dispatch_ready);
    done = 0;
    for (int t = 0; t < n_tests && !timed_out; t++) begin
      run_test(t);
      done = done + 1;
    end
    $display("tests run %0d of %0d, errors %0d", done, n_tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
